/* compile.f */
+incdir+hw
hw/cdc_fifo_pkg.sv
hw/cdc_ptr_sync.sv
hw/cdc_wr_ctrl.sv
hw/cdc_rd_ctrl.sv
hw/cdc_fifo_mem.sv
hw/cdc_fifo.sv
verif/cdc_fifo_chk.sv
verif/cdc_fifo_tb.sv

/* hw/cdc_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module cdc_fifo (
  input  logic                i_wclk,
  input  logic                i_wcg,
  input  logic                i_rclk,
  input  logic                i_rcg,
  input  logic                i_rst_n,
  input  cdc_fifo_pkg::data_t i_wdata,
  input  logic                i_wvalid,
  output logic                o_wready,
  output cdc_fifo_pkg::data_t o_rdata,
  output logic                o_rvalid,
  input  logic                i_rready
);

  logic                wen;
  cdc_fifo_pkg::addr_t waddr;
  cdc_fifo_pkg::addr_t raddr;
  cdc_fifo_pkg::ptr_t  wptr_gray;
  cdc_fifo_pkg::ptr_t  rptr_gray;
  cdc_fifo_pkg::ptr_t  wptr_bin_rd;  // write ptr seen by reader
  cdc_fifo_pkg::ptr_t  rptr_bin_wr;  // read ptr seen by writer

  cdc_wr_ctrl u_wr_ctrl (
    .i_wclk      (i_wclk),
    .i_wcg       (i_wcg),
    .i_rst_n     (i_rst_n),
    .i_wvalid    (i_wvalid),
    .i_rptr_bin  (rptr_bin_wr),
    .o_wready    (o_wready),
    .o_wen       (wen),
    .o_waddr     (waddr),
    .o_wptr_gray (wptr_gray)
  );

  cdc_ptr_sync u_sync_w2r (
    .i_clk      (i_rclk),
    .i_cg       (i_rcg),
    .i_rst_n    (i_rst_n),
    .i_ptr_gray (wptr_gray),
    .o_ptr_bin  (wptr_bin_rd)
  );

  cdc_rd_ctrl u_rd_ctrl (
    .i_rclk      (i_rclk),
    .i_rcg       (i_rcg),
    .i_rst_n     (i_rst_n),
    .i_rready    (i_rready),
    .i_wptr_bin  (wptr_bin_rd),
    .o_rvalid    (o_rvalid),
    .o_raddr     (raddr),
    .o_rptr_gray (rptr_gray)
  );

  cdc_ptr_sync u_sync_r2w (
    .i_clk      (i_wclk),
    .i_cg       (i_wcg),
    .i_rst_n    (i_rst_n),
    .i_ptr_gray (rptr_gray),
    .o_ptr_bin  (rptr_bin_wr)
  );

  cdc_fifo_mem u_mem (
    .i_wclk  (i_wclk),
    .i_wcg   (i_wcg),
    .i_wen   (wen),
    .i_waddr (waddr),
    .i_wdata (i_wdata),
    .i_raddr (raddr),
    .o_rdata (o_rdata)
  );

endmodule

`default_nettype wire

/* hw/cdc_fifo_mem.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cdc_fifo_settings.svh"

module cdc_fifo_mem (
  input  logic                i_wclk,
  input  logic                i_wcg,
  input  logic                i_wen,
  input  cdc_fifo_pkg::addr_t i_waddr,
  input  cdc_fifo_pkg::data_t i_wdata,
  input  cdc_fifo_pkg::addr_t i_raddr,
  output cdc_fifo_pkg::data_t o_rdata
);

  localparam int DEPTH = `CDC_FIFO_DEPTH;

  cdc_fifo_pkg::data_t entries_q [DEPTH];

  always_ff @(posedge i_wclk) begin
    if (i_wcg && i_wen) begin
      entries_q[i_waddr] <= i_wdata;
    end
  end

  // read side only points at slots whose write already crossed over
  assign o_rdata = entries_q[i_raddr];

endmodule

`default_nettype wire

/* hw/cdc_fifo_pkg.sv */
`default_nettype none

`include "cdc_fifo_settings.svh"

package cdc_fifo_pkg;

  localparam int ADDR_W = $clog2(`CDC_FIFO_DEPTH);  // storage index bits
  localparam int PTR_W  = ADDR_W + 1;                // plus wrap bit

  // storage index
  typedef logic [ADDR_W-1:0] addr_t;

  // binary or gray pointer, msb is the wrap bit
  typedef logic [PTR_W-1:0] ptr_t;

  // payload word
  typedef logic [`CDC_FIFO_WIDTH-1:0] data_t;

endpackage

`default_nettype wire

/* hw/cdc_fifo_settings.svh */
`ifndef CDC_FIFO_SETTINGS_SVH
`define CDC_FIFO_SETTINGS_SVH

// entry count, keep it a power of two
`define CDC_FIFO_DEPTH 8

`define CDC_FIFO_WIDTH 16        // data word bits

`define CDC_FIFO_SYNC_STAGES 2   // flops per crossing

`endif

/* hw/cdc_ptr_sync.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cdc_fifo_settings.svh"

module cdc_ptr_sync (
  input  logic               i_clk,
  input  logic               i_cg,
  input  logic               i_rst_n,
  input  cdc_fifo_pkg::ptr_t i_ptr_gray,
  output cdc_fifo_pkg::ptr_t o_ptr_bin
);

  localparam int STAGES = `CDC_FIFO_SYNC_STAGES;
  localparam int PTR_W  = cdc_fifo_pkg::PTR_W;

  cdc_fifo_pkg::ptr_t sync_q [STAGES];  // [0] may go metastable
  cdc_fifo_pkg::ptr_t gray_sync;
  cdc_fifo_pkg::ptr_t bin_comb;

  // each bit travels on its own, source gray moves one bit at a time
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int s = 0; s < STAGES; s++) begin
        sync_q[s] <= '0;
      end
    end else if (i_cg) begin
      sync_q[0] <= i_ptr_gray;
      for (int s = 1; s < STAGES; s++) begin
        sync_q[s] <= sync_q[s-1];
      end
    end
  end

  assign gray_sync = sync_q[STAGES-1];  // last stage is stable

  // gray to binary, xor prefix from the msb down
  always_comb begin
    for (int b = 0; b < PTR_W; b++) begin
      bin_comb[b] = ^(gray_sync >> b);
    end
  end

  assign o_ptr_bin = bin_comb;

endmodule

`default_nettype wire

/* hw/cdc_rd_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module cdc_rd_ctrl (
  input  logic                i_rclk,
  input  logic                i_rcg,
  input  logic                i_rst_n,
  input  logic                i_rready,
  input  cdc_fifo_pkg::ptr_t  i_wptr_bin,
  output logic                o_rvalid,
  output cdc_fifo_pkg::addr_t o_raddr,
  output cdc_fifo_pkg::ptr_t  o_rptr_gray
);

  localparam int ADDR_W = cdc_fifo_pkg::ADDR_W;

  cdc_fifo_pkg::ptr_t rptr_bin_q;
  cdc_fifo_pkg::ptr_t rptr_gray_q;
  cdc_fifo_pkg::ptr_t rptr_bin_nxt;
  cdc_fifo_pkg::ptr_t rptr_gray_nxt;

  logic empty;
  logic consume;

  // empty only on a full match, wrap bit included
  assign empty   = (rptr_bin_q == i_wptr_bin);
  assign consume = i_rcg && i_rready && !empty;

  assign rptr_bin_nxt  = cdc_fifo_pkg::ptr_t'(rptr_bin_q + 1'b1);
  assign rptr_gray_nxt = rptr_bin_nxt ^ (rptr_bin_nxt >> 1);

  always_ff @(posedge i_rclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rptr_bin_q  <= '0;
      rptr_gray_q <= '0;
    end else if (consume) begin
      rptr_bin_q  <= rptr_bin_nxt;
      rptr_gray_q <= rptr_gray_nxt;
    end
  end

  // read address follows the pointer, data shows up right away
  assign o_raddr     = rptr_bin_q[ADDR_W-1:0];
  assign o_rvalid    = !empty;
  assign o_rptr_gray = rptr_gray_q;

endmodule

`default_nettype wire

/* hw/cdc_wr_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module cdc_wr_ctrl (
  input  logic                i_wclk,
  input  logic                i_wcg,
  input  logic                i_rst_n,
  input  logic                i_wvalid,
  input  cdc_fifo_pkg::ptr_t  i_rptr_bin,
  output logic                o_wready,
  output logic                o_wen,
  output cdc_fifo_pkg::addr_t o_waddr,
  output cdc_fifo_pkg::ptr_t  o_wptr_gray
);

  localparam int ADDR_W = cdc_fifo_pkg::ADDR_W;

  cdc_fifo_pkg::ptr_t wptr_bin_q;
  cdc_fifo_pkg::ptr_t wptr_gray_q;
  cdc_fifo_pkg::ptr_t wptr_bin_nxt;
  cdc_fifo_pkg::ptr_t wptr_gray_nxt;

  logic addr_match;
  logic wrap_differ;
  logic full;
  logic accept;

  // full when same slot but one lap ahead of the reader
  assign addr_match  = (wptr_bin_q[ADDR_W-1:0] == i_rptr_bin[ADDR_W-1:0]);
  assign wrap_differ = (wptr_bin_q[ADDR_W] != i_rptr_bin[ADDR_W]);
  assign full        = addr_match && wrap_differ;

  assign accept = i_wcg && i_wvalid && !full;

  assign wptr_bin_nxt  = cdc_fifo_pkg::ptr_t'(wptr_bin_q + 1'b1);
  assign wptr_gray_nxt = wptr_bin_nxt ^ (wptr_bin_nxt >> 1);

  // gray copy is registered so the crossing sees clean flop outputs
  always_ff @(posedge i_wclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wptr_bin_q  <= '0;
      wptr_gray_q <= '0;
    end else if (accept) begin
      wptr_bin_q  <= wptr_bin_nxt;
      wptr_gray_q <= wptr_gray_nxt;
    end
  end

  assign o_wready    = !full;
  assign o_wen       = accept;                  // strobe to storage
  assign o_waddr     = wptr_bin_q[ADDR_W-1:0];
  assign o_wptr_gray = wptr_gray_q;

endmodule

`default_nettype wire

/* verif/cdc_fifo_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module cdc_fifo_chk (
  input logic                i_wclk,
  input logic                i_rclk,
  input logic                i_rst_n,
  input logic                i_wen,
  input logic                i_wready,
  input logic                i_rvalid,
  input logic                i_rready,
  input cdc_fifo_pkg::data_t i_rdata,
  input cdc_fifo_pkg::ptr_t  i_wptr_gray,
  input cdc_fifo_pkg::ptr_t  i_rptr_gray
);

  localparam int PTR_W = cdc_fifo_pkg::PTR_W;
  localparam int DEPTH = 2 ** cdc_fifo_pkg::ADDR_W;

  int unsigned        err_count = 0;  // assertion failures so far
  cdc_fifo_pkg::ptr_t fill_level;

  // each binary bit is the next higher binary bit xor this gray bit
  function automatic cdc_fifo_pkg::ptr_t gray_decode(input cdc_fifo_pkg::ptr_t g);
    cdc_fifo_pkg::ptr_t b;
    b[PTR_W-1] = g[PTR_W-1];
    for (int i = PTR_W - 2; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  // words held as seen from the live pointers of both sides
  assign fill_level = gray_decode(i_wptr_gray) - gray_decode(i_rptr_gray);

  a_no_accept_full: assert property (@(posedge i_wclk) disable iff (!i_rst_n)
    i_wen |-> (fill_level < cdc_fifo_pkg::ptr_t'(DEPTH)))
    else begin
      err_count++;
      $error("write strobe while the FIFO is full");
    end

  // head word must not move while the sink stalls
  a_rdata_stable: assert property (@(posedge i_rclk) disable iff (!i_rst_n)
    (i_rvalid && !i_rready) |=> (i_rvalid && $stable(i_rdata)))
    else begin
      err_count++;
      $error("read data or valid moved under back-pressure");
    end

  a_wgray_step: assert property (@(posedge i_wclk) disable iff (!i_rst_n)
    $countones(i_wptr_gray ^ $past(i_wptr_gray)) <= 1)
    else begin
      err_count++;
      $error("write gray pointer changed more than one bit");
    end

  a_rgray_step: assert property (@(posedge i_rclk) disable iff (!i_rst_n)
    $countones(i_rptr_gray ^ $past(i_rptr_gray)) <= 1)
    else begin
      err_count++;
      $error("read gray pointer changed more than one bit");
    end

  a_rst_wready: assert property (@(posedge i_wclk) !i_rst_n |-> i_wready)
    else begin
      err_count++;
      $error("write ready low during reset");
    end

  a_rst_rvalid: assert property (@(posedge i_rclk) !i_rst_n |-> !i_rvalid)
    else begin
      err_count++;
      $error("read valid high during reset");
    end

endmodule

bind cdc_fifo cdc_fifo_chk u_chk (
  .i_wclk      (i_wclk),
  .i_rclk      (i_rclk),
  .i_rst_n     (i_rst_n),
  .i_wen       (wen),
  .i_wready    (o_wready),
  .i_rvalid    (o_rvalid),
  .i_rready    (i_rready),
  .i_rdata     (o_rdata),
  .i_wptr_gray (wptr_gray),
  .i_rptr_gray (rptr_gray)
);

`default_nettype wire

/* verif/cdc_fifo_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cdc_fifo_settings.svh"

module cdc_fifo_tb;

  localparam int          WCLK_HALF  = 2;
  localparam int          RCLK_HALF  = 3;
  localparam int          DEPTH      = `CDC_FIFO_DEPTH;
  localparam int          N_WORDS    = 400;
  localparam int          TIMEOUT_NS = N_WORDS * (2 * RCLK_HALF) * 20;  // slower period times 20
  localparam logic [31:0] SEED       = 32'h94fe41ba;

  logic                i_wclk;
  logic                i_wcg;
  logic                i_rclk;
  logic                i_rcg;
  logic                i_rst_n;
  cdc_fifo_pkg::data_t i_wdata;
  logic                i_wvalid;
  logic                o_wready;
  cdc_fifo_pkg::data_t o_rdata;
  logic                o_rvalid;
  logic                i_rready;

  cdc_fifo_pkg::data_t model_q [$];
  int unsigned         accept_count;
  int unsigned         consume_count;
  logic                writes_done;
  logic [31:0]         w_state;
  logic [31:0]         r_state;
  logic                hold_pending;
  logic                held_valid;
  cdc_fifo_pkg::data_t held_data;
  cdc_fifo_pkg::data_t exp_word;

  cdc_fifo u_dut (
    .i_wclk   (i_wclk),
    .i_wcg    (i_wcg),
    .i_rclk   (i_rclk),
    .i_rcg    (i_rcg),
    .i_rst_n  (i_rst_n),
    .i_wdata  (i_wdata),
    .i_wvalid (i_wvalid),
    .o_wready (o_wready),
    .o_rdata  (o_rdata),
    .o_rvalid (o_rvalid),
    .i_rready (i_rready)
  );

  initial begin
    i_wclk = 1'b0;
    forever #(WCLK_HALF) i_wclk = ~i_wclk;
  end

  initial begin
    i_rclk = 1'b0;
    forever #(RCLK_HALF) i_rclk = ~i_rclk;  // drifts against i_wclk
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // reference model keeps words in accept order
  function automatic void push_expected(input cdc_fifo_pkg::data_t w);
    model_q.push_back(w);
  endfunction

  function automatic cdc_fifo_pkg::data_t pop_expected();
    return model_q.pop_front();
  endfunction

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic value_error(input string sig, input cdc_fifo_pkg::data_t got,
                             input cdc_fifo_pkg::data_t exp);
    fail_run($sformatf("ERROR at %0t ns: %s got %h, expected %h", $time, sig, got, exp));
  endtask

  always @(posedge i_wclk) begin
    if (i_rst_n && i_wcg && i_wvalid && o_wready) begin
      push_expected(i_wdata);
      accept_count++;
    end
  end

  // write pointer may only move on counted accepts
  always @(negedge i_wclk) begin
    if (i_rst_n) begin
      assert (u_dut.u_wr_ctrl.wptr_bin_q == cdc_fifo_pkg::ptr_t'(accept_count))
        else fail_run("write pointer moved without an accept");
    end
  end

  always @(u_dut.u_chk.err_count) begin
    assert (u_dut.u_chk.err_count == 0)
      else fail_run("the bound assertion checker reported errors");
  end

  always @(posedge i_rclk) begin
    if (i_rst_n) begin
      if (hold_pending) begin
        assert (o_rvalid === held_valid)
          else fail_run("o_rvalid changed while i_rcg was low");
        if (held_valid) begin
          assert (o_rdata === held_data)
            else value_error("o_rdata", o_rdata, held_data);
        end
      end
      hold_pending = !i_rcg;
      held_valid   = o_rvalid;
      held_data    = o_rdata;
      if (i_rcg && o_rvalid && i_rready) begin
        assert (model_q.size() > 0)
          else fail_run("a word was consumed that was never accepted");
        exp_word = pop_expected();
        assert (o_rdata === exp_word)
          else value_error("o_rdata", o_rdata, exp_word);
        consume_count++;
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    fail_run("timeout: the run did not finish in the expected time");
  end

  task automatic fill_fifo();
    cdc_fifo_pkg::data_t first_word;
    while (accept_count < DEPTH) begin
      @(negedge i_wclk);
      if (accept_count < DEPTH) begin
        assert (o_wready)
          else fail_run("o_wready dropped before the FIFO was full");
        w_state  = lcg_next(w_state);
        i_wdata  = cdc_fifo_pkg::data_t'(w_state >> 8);
        i_wvalid = 1'b1;
      end
    end
    // keep pushing against a full FIFO
    repeat (20) begin
      @(negedge i_wclk);
      assert (!o_wready)
        else fail_run("o_wready rose while the FIFO was full");
      w_state = lcg_next(w_state);
      i_wdata = cdc_fifo_pkg::data_t'(w_state >> 8);
    end
    assert (accept_count == DEPTH)
      else fail_run("accept count differs from the depth with reads held off");
    i_wvalid = 1'b0;
    @(negedge i_rclk);
    while (!o_rvalid) @(negedge i_rclk);
    first_word = model_q[0];
    repeat (10) begin
      assert (o_rvalid)
        else fail_run("o_rvalid dropped with no read");
      assert (o_rdata === first_word)
        else value_error("o_rdata", o_rdata, first_word);
      @(negedge i_rclk);
    end
  endtask

  task automatic drive_writes(input int unsigned target);
    while (accept_count < target) begin
      @(negedge i_wclk);
      if (accept_count < target) begin
        w_state  = lcg_next(w_state);
        i_wdata  = cdc_fifo_pkg::data_t'(w_state >> 8);
        i_wvalid = (w_state[31:30] != 2'b00);
        i_wcg    = (w_state[29:27] != 3'b000);  // clock gated about 1 in 8
      end
    end
    i_wvalid    = 1'b0;
    i_wcg       = 1'b1;
    writes_done = 1'b1;
  endtask

  task automatic drive_reads();
    logic finished;
    finished = 1'b0;
    while (!finished) begin
      @(negedge i_rclk);
      if (writes_done && consume_count == accept_count) begin
        finished = 1'b1;
      end else begin
        r_state  = lcg_next(r_state);
        i_rready = (r_state[31:30] != 2'b00);
        i_rcg    = (r_state[29:27] != 3'b000);
      end
    end
    // sink keeps asking after the drain
    i_rready = 1'b1;
    i_rcg    = 1'b1;
    repeat (20) begin
      assert (!o_rvalid)
        else fail_run("o_rvalid high after every accepted word was read");
      @(negedge i_rclk);
    end
    assert (u_dut.u_rd_ctrl.rptr_bin_q == cdc_fifo_pkg::ptr_t'(accept_count))
      else fail_run("read pointer does not match the number of accepted words");
  endtask

  initial begin
    i_wcg         = 1'b1;
    i_rcg         = 1'b1;
    i_rst_n       = 1'b1;
    i_wvalid      = 1'b0;
    i_wdata       = '0;
    i_rready      = 1'b0;
    accept_count  = 0;
    consume_count = 0;
    writes_done   = 1'b0;
    hold_pending  = 1'b0;
    held_valid    = 1'b0;
    held_data     = '0;
    w_state       = SEED;
    r_state       = lcg_next(SEED ^ 32'h0000ffff);

    #1 i_rst_n = 1'b0;  // clean falling edge for the async reset
    repeat (5) @(posedge i_wclk);
    @(negedge i_wclk);
    i_rst_n = 1'b1;

    assert (o_rvalid === 1'b0)
      else fail_run("o_rvalid is not low after reset");
    assert (o_wready === 1'b1)
      else fail_run("o_wready is not high after reset");

    fill_fifo();

    fork
      drive_writes(N_WORDS);
      drive_reads();
    join

    @(negedge i_wclk);
    if (u_dut.u_chk.err_count == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      fail_run("the bound assertion checker reported errors");
    end
  end

endmodule

`default_nettype wire
